//--- emesh_settings.svh
`ifndef EMESH_SETTINGS_SVH
`define EMESH_SETTINGS_SVH

//############################################################################
// Mesh packet format
//############################################################################

`define EMESH_PW        104      // Full emesh packet width

//############################################################################
// Memory array sizing
//############################################################################

`define EMESH_NODES     4        // Memory nodes behind the router
`define EMEM_DEPTH      16       // Words held by each node
`define EMEM_FIFO_DEPTH 4        // Entries in every request/response FIFO

//############################################################################
// Address map
//############################################################################

`define EMESH_BASE_ID   12'h810  // Chip id served by node 0

// Ids from EMESH_BASE_ID up to EMESH_BASE_ID+EMESH_NODES-1 map onto nodes
// in order. Anything else is dropped by the router.

`endif

//--- emesh_pkg.sv
package emesh_pkg;

   //#########################################################################
   // Basic mesh fields
   //#########################################################################

   typedef logic [31:0] addr_t;    // Source and destination address
   typedef logic [31:0] data_t;    // One data word
   typedef logic [11:0] chipid_t;  // Upper 12 bits of dstaddr
   typedef logic [3:0]  ctrlmode_t; // Mesh control mode
   typedef logic [1:0]  datamode_t; // Transfer size

   //#########################################################################
   // Packet layout, MSB first
   //#########################################################################

   // 104 bits in total
   //  [103:72] srcaddr
   //  [71:40]  data
   //  [39:8]   dstaddr (chip id in [39:28])
   //  [7:4]    ctrlmode
   //  [3:2]    datamode
   //  [1]      write
   //  [0]      spare
   typedef struct packed {
      addr_t     srcaddr;   // Return address for reads
      data_t     data;      // Write data or read payload
      addr_t     dstaddr;   // Target address
      ctrlmode_t ctrlmode;  // Unused by the memory
      datamode_t datamode;  // Unused by the memory
      logic      write;     // 1 for write, 0 for read
      logic      spare;     // Always zero
   } emesh_packet_t;

   // Chip id of a packet's destination
   function automatic chipid_t packet_chipid(input emesh_packet_t pkt);
      return pkt.dstaddr[31:20];  // Same as packet bits 39:28
   endfunction

endpackage

//--- emem_pkg.sv
`include "emesh_settings.svh"

package emem_pkg;

   //#########################################################################
   // Memory node types
   //#########################################################################

   // Word index from dstaddr[5:2], sized by node depth
   typedef logic [$clog2(`EMEM_DEPTH)-1:0] word_idx_t;

   // Node index, sized by node count
   typedef logic [$clog2(`EMESH_NODES)-1:0] node_idx_t;

   // Read response as held in the node response FIFO
   typedef struct packed {
      emesh_pkg::addr_t dstaddr;  // Copied from request srcaddr
      emesh_pkg::data_t data;     // Stored word
   } rresp_t;

   // Word index taken from a byte address
   function automatic word_idx_t addr_word(input emesh_pkg::addr_t addr);
      return addr[2 +: $bits(word_idx_t)];  // Word aligned, drop byte bits
   endfunction

endpackage

//--- packet_fifo.sv
`include "emesh_settings.svh"

module packet_fifo #(
   parameter type payload_t = emesh_pkg::emesh_packet_t
) (
   input  logic     clkin,
   input  logic     reset,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t pop_data,
   output logic     empty,
   output logic     full
);

   localparam int DEPTH = `EMEM_FIFO_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t      mem [DEPTH];  // Entry storage
   logic [AW-1:0] wr_ptr;       // Next slot to fill
   logic [AW-1:0] rd_ptr;       // Current head
   logic [AW:0]   count;        // Entries held
   logic          do_push;
   logic          do_pop;

   assign do_push = push & ~full;   // Overflow ignored
   assign do_pop  = pop & ~empty;   // Underflow ignored

   assign empty    = (count == '0);
   assign full     = (count == (AW+1)'(DEPTH));
   assign pop_data = mem[rd_ptr];   // Head visible without a pop

   // Storage
   always_ff @(posedge clkin) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers and fill level
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;  // Wrap
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;  // Wrap
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

endmodule

//--- emesh_router.sv
`include "emesh_settings.svh"

module emesh_router (
   input  logic                     ext_access,
   input  emesh_pkg::emesh_packet_t ext_packet,
   input  logic [`EMESH_NODES-1:0]  req_full,
   output logic                     rd_wait,
   output logic                     wr_wait,
   output logic [`EMESH_NODES-1:0]  req_push,
   output emesh_pkg::emesh_packet_t req_packet
);

   localparam int NW = (`EMESH_NODES > 1) ? $clog2(`EMESH_NODES) : 1;

   emesh_pkg::chipid_t chip_ofs;     // Id relative to node 0
   logic               in_range;     // Id owned by one of the nodes
   logic [NW-1:0]      target;       // Selected node
   logic               target_full;  // Selected request FIFO is full
   logic               take;         // Packet accepted this cycle

   //#########################################################################
   // Address decode
   //#########################################################################

   assign chip_ofs = emesh_pkg::packet_chipid(ext_packet) -
                     emesh_pkg::chipid_t'(`EMESH_BASE_ID);   // Wraps below base
   assign in_range = (chip_ofs < `EMESH_NODES);              // Else drop target
   assign target   = chip_ofs[NW-1:0];

   // Drop targets never wait
   assign target_full = in_range & req_full[target];

   //#########################################################################
   // Pushback and dispatch
   //#########################################################################

   // Wait only for the kind of the packet on offer
   assign rd_wait = ext_access & target_full & ~ext_packet.write;
   assign wr_wait = ext_access & target_full &  ext_packet.write;

   assign take = ext_access & in_range & ~target_full;  // Out of range just vanishes

   always_comb begin
      req_push = '0;
      if (take) begin
         req_push[target] = 1'b1;  // One node only
      end
   end

   // Shared request bus, qualified by req_push
   assign req_packet = ext_packet;

endmodule

//--- emem_node.sv
`include "emesh_settings.svh"

module emem_node (
   input  logic                     clkin,
   input  logic                     reset,
   input  logic                     req_push,
   input  emesh_pkg::emesh_packet_t req_packet,
   output logic                     req_full,
   input  logic                     rsp_pop,
   output logic                     rsp_valid,
   output emem_pkg::rresp_t         rsp_data
);

   emesh_pkg::emesh_packet_t req_head;   // Oldest request
   logic                     req_empty;
   logic                     req_pop;
   logic                     head_vld;   // Head seen for a full cycle
   emem_pkg::word_idx_t      widx;       // Word addressed by head
   emesh_pkg::data_t         words [`EMEM_DEPTH];
   logic                     rsp_push;
   emem_pkg::rresp_t         rsp_next;   // Response built from head
   logic                     rsp_empty;
   logic                     rsp_full;

   //#########################################################################
   // Request queue
   //#########################################################################

   packet_fifo #(
      .payload_t (emesh_pkg::emesh_packet_t)
   ) u_req_fifo (
      .clkin     (clkin),
      .reset     (reset),
      .push      (req_push),
      .push_data (req_packet),
      .pop       (req_pop),
      .pop_data  (req_head),
      .empty     (req_empty),
      .full      (req_full)
   );

   // Head is served one cycle after it shows up
   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         head_vld <= 1'b0;
      end else begin
         head_vld <= ~req_empty & ~req_pop;  // Next head needs its own cycle
      end
   end

   // Reads stall on a full response queue, writes never do
   assign req_pop = head_vld & (req_head.write | ~rsp_full);
   assign widx    = emem_pkg::addr_word(req_head.dstaddr);

   //#########################################################################
   // Word storage
   //#########################################################################

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         words <= '{default: '0};  // Memory reads zero after reset
      end else if (req_pop & req_head.write) begin
         words[widx] <= req_head.data;
      end
   end

   //#########################################################################
   // Response queue
   //#########################################################################

   assign rsp_push         = req_pop & ~req_head.write;
   assign rsp_next.dstaddr = req_head.srcaddr;  // Reply goes back to source
   assign rsp_next.data    = words[widx];

   packet_fifo #(
      .payload_t (emem_pkg::rresp_t)
   ) u_rsp_fifo (
      .clkin     (clkin),
      .reset     (reset),
      .push      (rsp_push),
      .push_data (rsp_next),
      .pop       (rsp_pop),
      .pop_data  (rsp_data),
      .empty     (rsp_empty),
      .full      (rsp_full)
   );

   assign rsp_valid = ~rsp_empty;

endmodule

//--- resp_arbiter.sv
`include "emesh_settings.svh"

module resp_arbiter (
   input  logic                     clkin,
   input  logic                     reset,
   input  logic [`EMESH_NODES-1:0]  rsp_valid,
   input  emem_pkg::rresp_t         rsp_data [`EMESH_NODES],
   input  logic                     resp_wait,
   output logic [`EMESH_NODES-1:0]  rsp_pop,
   output logic                     dut_access,
   output emesh_pkg::emesh_packet_t dut_packet
);

   emem_pkg::node_idx_t      last_grant;  // Round-robin pointer
   emem_pkg::node_idx_t      grant;       // Winner this cycle
   logic                     found;       // Any node has a response
   logic                     load;        // Output register may take new data
   emesh_pkg::emesh_packet_t pkt_next;    // Rebuilt response packet

   //#########################################################################
   // Round-robin pick, starting after the last grant
   //#########################################################################

   always_comb begin
      found = 1'b0;
      grant = last_grant;
      for (int i = 1; i <= `EMESH_NODES; i++) begin
         if (!found && rsp_valid[(int'(last_grant) + i) % `EMESH_NODES]) begin
            found = 1'b1;
            grant = emem_pkg::node_idx_t'((int'(last_grant) + i) % `EMESH_NODES);
         end
      end
   end

   // Output register free or not held
   assign load = ~dut_access | ~resp_wait;

   assign rsp_pop = (load & found) ? (`EMESH_NODES'(1) << grant) : '0;

   //#########################################################################
   // Response packet
   //#########################################################################

   always_comb begin
      pkt_next         = '0;                      // Src, modes zero
      pkt_next.dstaddr = rsp_data[grant].dstaddr;
      pkt_next.data    = rsp_data[grant].data;
      pkt_next.write   = 1'b1;                    // Responses travel as writes
   end

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         dut_access <= 1'b0;
         last_grant <= emem_pkg::node_idx_t'(`EMESH_NODES-1);  // Node 0 first
      end else if (load) begin
         dut_access <= found;
         if (found) begin
            last_grant <= grant;
         end
      end
   end

   // Holds while resp_wait stalls a valid output
   always_ff @(posedge clkin) begin
      if (load & found) begin
         dut_packet <= pkt_next;
      end
   end

endmodule

//--- emesh_mem_array.sv
`include "emesh_settings.svh"

module emesh_mem_array (
   input  logic                     clkin,
   input  logic                     reset,
   input  logic                     ext_access,
   input  emesh_pkg::emesh_packet_t ext_packet,
   input  logic                     resp_wait,
   output logic                     rd_wait,
   output logic                     wr_wait,
   output logic                     dut_access,
   output emesh_pkg::emesh_packet_t dut_packet
);

   logic [`EMESH_NODES-1:0]  req_full;               // Per node pushback
   logic [`EMESH_NODES-1:0]  req_push;               // Per node strobe
   emesh_pkg::emesh_packet_t req_packet;             // Shared request bus
   logic [`EMESH_NODES-1:0]  rsp_valid;
   logic [`EMESH_NODES-1:0]  rsp_pop;
   emem_pkg::rresp_t         rsp_data [`EMESH_NODES];

   //#########################################################################
   // Request side
   //#########################################################################

   emesh_router u_router (
      .ext_access (ext_access),
      .ext_packet (ext_packet),
      .req_full   (req_full),
      .rd_wait    (rd_wait),
      .wr_wait    (wr_wait),
      .req_push   (req_push),
      .req_packet (req_packet)
   );

   for (genvar i = 0; i < `EMESH_NODES; i++) begin : g_node
      emem_node u_node (
         .clkin      (clkin),
         .reset      (reset),
         .req_push   (req_push[i]),
         .req_packet (req_packet),
         .req_full   (req_full[i]),
         .rsp_pop    (rsp_pop[i]),
         .rsp_valid  (rsp_valid[i]),
         .rsp_data   (rsp_data[i])
      );
   end

   //#########################################################################
   // Response side
   //#########################################################################

   resp_arbiter u_arb (
      .clkin      (clkin),
      .reset      (reset),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .resp_wait  (resp_wait),
      .rsp_pop    (rsp_pop),
      .dut_access (dut_access),
      .dut_packet (dut_packet)
   );

endmodule

//--- tb_scoreboard.sv
`include "emesh_settings.svh"

module tb_scoreboard (
   input  logic                     clkin,
   input  logic                     reset,
   input  logic                     ext_access,
   input  emesh_pkg::emesh_packet_t ext_packet,
   input  logic                     rd_wait,
   input  logic                     wr_wait,
   input  logic                     resp_wait,
   input  logic                     dut_access,
   input  emesh_pkg::emesh_packet_t dut_packet,
   output logic                     error_flag,
   output int                       reads_in_range,
   output int                       responses,
   output int                       pending
);

   timeunit 1ns;
   timeprecision 100ps;

   emesh_pkg::data_t         model [`EMESH_NODES][`EMEM_DEPTH];  // Reference memory
   emesh_pkg::data_t         expect_by_tag [emesh_pkg::addr_t];  // Open reads by tag
   logic                     hold_prev;   // Output stalled at last edge
   emesh_pkg::emesh_packet_t held_pkt;    // Packet seen at that edge

   initial begin
      error_flag     = 1'b0;
      reads_in_range = 0;
      responses      = 0;
      pending        = 0;
      hold_prev      = 1'b0;
      for (int n = 0; n < `EMESH_NODES; n++) begin
         for (int w = 0; w < `EMEM_DEPTH; w++) begin
            model[n][w] = '0;  // Memory starts cleared
         end
      end
   end

   // Node from chip id, -1 when outside the node range
   function automatic int target_node(input emesh_pkg::emesh_packet_t p);
      int ofs;
      ofs = int'(p.dstaddr[31:20]) - int'(`EMESH_BASE_ID);
      return (ofs >= 0 && ofs < `EMESH_NODES) ? ofs : -1;
   endfunction

   function automatic int word_index(input emesh_pkg::emesh_packet_t p);
      return int'(p.dstaddr[5:2]);  // Word aligned address
   endfunction

   task automatic report_error(input string msg);
      $display("%s", msg);
      error_flag = 1'b1;  // Top stops the run
   endtask

   //#########################################################################
   // Request side model
   //#########################################################################

   task automatic accept_request(input emesh_pkg::emesh_packet_t p);
      int node;
      node = target_node(p);
      if (node >= 0) begin
         if (p.write) begin
            model[node][word_index(p)] = p.data;
         end else begin
            expect_by_tag[p.srcaddr] = model[node][word_index(p)];  // Value at acceptance
            reads_in_range++;
         end
      end
   endtask

   //#########################################################################
   // Response side checks
   //#########################################################################

   task automatic check_response(input emesh_pkg::emesh_packet_t p);
      emesh_pkg::addr_t tag;
      tag = p.dstaddr;
      assert (expect_by_tag.exists(tag)) else
         report_error($sformatf("Response to %h matches no outstanding read", tag));
      if (expect_by_tag.exists(tag)) begin
         assert (p.data === expect_by_tag[tag]) else
            report_error($sformatf("ERR dut_packet.data tag %h: expected %h, got %h",
                                   tag, expect_by_tag[tag], p.data));
         expect_by_tag.delete(tag);
      end
      // Src zero, modes zero, write set, spare clear
      assert ({p.srcaddr, p.ctrlmode, p.datamode, p.write, p.spare} === 40'h2) else
         report_error($sformatf("ERR dut_packet control: expected %h, got %h", 40'h2,
                                {p.srcaddr, p.ctrlmode, p.datamode, p.write, p.spare}));
      responses++;
   endtask

   always @(posedge clkin) begin
      if (!reset) begin
         if (hold_prev) begin  // Stalled output must not move
            assert (dut_access === 1'b1) else
               report_error($sformatf("ERR dut_access held: expected 1, got %h", dut_access));
            assert (dut_packet === held_pkt) else
               report_error($sformatf("ERR dut_packet held: expected %h, got %h",
                                      held_pkt, dut_packet));
         end
         hold_prev = dut_access & resp_wait;
         held_pkt  = dut_packet;
         if (dut_access && !resp_wait) begin
            check_response(dut_packet);  // Consumed this edge
         end
         if (ext_access && !(ext_packet.write ? wr_wait : rd_wait)) begin
            accept_request(ext_packet);
         end
         pending = expect_by_tag.num();
      end
   end

endmodule

//--- tb_emesh_mem_array.sv
`include "emesh_settings.svh"

module tb_emesh_mem_array;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_CYCLES = 4000;  // About four times the stimulus

   logic                     clkin;
   logic                     reset;
   logic                     ext_access;
   emesh_pkg::emesh_packet_t ext_packet;
   logic                     resp_wait;
   logic                     rd_wait;
   logic                     wr_wait;
   logic                     dut_access;
   emesh_pkg::emesh_packet_t dut_packet;
   logic                     sb_error;
   int                       reads_in_range;
   int                       responses;
   int                       pending;

   int          seed        = 32'hd3bb;
   int          cycles      = 0;
   int          wait_mode   = 0;      // 0 low, 1 random, 2 held for hold_left
   int          hold_left   = 0;
   logic        saw_rd_wait = 1'b0;
   logic [31:0] next_tag    = 32'h1000_0000;  // Unique read srcaddr

   emesh_mem_array u_dut (
      .clkin      (clkin),
      .reset      (reset),
      .ext_access (ext_access),
      .ext_packet (ext_packet),
      .resp_wait  (resp_wait),
      .rd_wait    (rd_wait),
      .wr_wait    (wr_wait),
      .dut_access (dut_access),
      .dut_packet (dut_packet)
   );

   tb_scoreboard u_sb (
      .clkin          (clkin),
      .reset          (reset),
      .ext_access     (ext_access),
      .ext_packet     (ext_packet),
      .rd_wait        (rd_wait),
      .wr_wait        (wr_wait),
      .resp_wait      (resp_wait),
      .dut_access     (dut_access),
      .dut_packet     (dut_packet),
      .error_flag     (sb_error),
      .reads_in_range (reads_in_range),
      .responses      (responses),
      .pending        (pending)
   );

   initial begin
      clkin = 1'b0;
      forever #20 clkin = ~clkin;  // 40 ns period
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "Run stopped at first error");
   endtask

   always @(posedge sb_error) fail_run("Scoreboard check failed");

   always @(posedge clkin) begin
      cycles++;
      if (rd_wait) saw_rd_wait = 1'b1;
      if (cycles >= MAX_CYCLES) fail_run("Timeout, run did not finish in time");
   end

   //#########################################################################
   // Stimulus helpers, all on the falling edge
   //#########################################################################

   task automatic next_edge();
      @(negedge clkin);
      case (wait_mode)
         1:       resp_wait = (($random(seed) & 3) == 0);  // Stall one in four
         2: begin
            resp_wait = (hold_left > 0);
            if (hold_left > 0) hold_left--;
         end
         default: resp_wait = 1'b0;
      endcase
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         next_edge();
         ext_access = 1'b0;
      end
   endtask

   // Offer one packet and keep it until the matching wait is low
   task automatic send_request(input logic [11:0] chip, input logic [3:0] word,
                               input logic wr, input logic [31:0] data);
      emesh_pkg::emesh_packet_t pkt;
      logic                     taken;
      pkt         = '0;
      pkt.dstaddr = {chip, 14'h0, word, 2'b00};
      pkt.write   = wr;
      pkt.data    = data;
      pkt.srcaddr = wr ? 32'($random(seed)) : next_tag;
      if (!wr) next_tag++;
      next_edge();
      ext_access = 1'b1;
      ext_packet = pkt;
      taken      = 1'b0;
      while (!taken) begin
         @(posedge clkin);
         taken = wr ? !wr_wait : !rd_wait;
         if (!taken) next_edge();
      end
   endtask

   task automatic expect_low(input string name, input logic value);
      assert (value === 1'b0) else fail_run($sformatf("ERR %s: expected 0, got %h", name, value));
   endtask

   //#########################################################################
   // Test sequence
   //#########################################################################

   initial begin
      int          node;
      logic [11:0] chip;
      reset      = 1'b1;
      ext_access = 1'b0;
      ext_packet = '0;
      resp_wait  = 1'b0;
      repeat (4) @(posedge clkin);
      @(negedge clkin);
      reset = 1'b0;
      @(posedge clkin);
      expect_low("dut_access", dut_access);
      expect_low("rd_wait", rd_wait);
      expect_low("wr_wait", wr_wait);

      for (int n = 0; n < `EMESH_NODES; n++) begin  // Unwritten words read zero
         for (int w = 0; w < 4; w++) begin
            send_request(12'(`EMESH_BASE_ID + n), 4'(w), 1'b0, '0);
         end
      end
      send_request(12'(`EMESH_BASE_ID - 1), 4'd2, 1'b1, 32'h1111_1111);  // Dropped
      send_request(12'(`EMESH_BASE_ID + `EMESH_NODES), 4'd2, 1'b1, 32'h2222_2222);
      send_request(12'h000, 4'd2, 1'b0, '0);
      send_request(12'(`EMESH_BASE_ID + `EMESH_NODES), 4'd2, 1'b0, '0);
      send_request(12'(`EMESH_BASE_ID), 4'd2, 1'b0, '0);  // Still zero

      for (int n = 0; n < `EMESH_NODES; n++) begin  // Same word, separate nodes
         send_request(12'(`EMESH_BASE_ID + n), 4'd5, 1'b1, 32'hA5A5_0000 + 32'(n * 'h1111));
      end
      for (int n = 0; n < `EMESH_NODES; n++) begin
         send_request(12'(`EMESH_BASE_ID + n), 4'd5, 1'b0, '0);
      end

      wait_mode = 1;  // Random mix under random resp_wait
      for (int i = 0; i < 400; i++) begin
         node = $random(seed) & 15;
         chip = (node < 14) ? 12'(`EMESH_BASE_ID + node % `EMESH_NODES)
                            : 12'(`EMESH_BASE_ID + `EMESH_NODES + node);
         send_request(chip, 4'($random(seed)), 1'($random(seed)), 32'($random(seed)));
         if (($random(seed) & 7) == 0) idle(1);
      end

      wait_mode   = 2;  // Sustained stall on node 1
      hold_left   = 60;
      saw_rd_wait = 1'b0;
      for (int i = 0; i < 12; i++) begin
         send_request(12'(`EMESH_BASE_ID + 1), 4'(i), 1'b0, '0);
      end
      idle(1);
      assert (saw_rd_wait) else fail_run("rd_wait never rose under sustained resp_wait");
      wait_mode = 0;

      while (pending != 0) @(posedge clkin);  // Drain, timeout guards
      idle(4);
      assert (responses == reads_in_range) else
         fail_run($sformatf("ERR responses: expected %h, got %h", reads_in_range, responses));

      if (sb_error) begin
         fail_run("Scoreboard check failed");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule

//--- emesh_mem_array.f
+incdir+.
emesh_pkg.sv
emem_pkg.sv
packet_fifo.sv
emesh_router.sv
emem_node.sv
resp_arbiter.sv
emesh_mem_array.sv
tb_scoreboard.sv
tb_emesh_mem_array.sv

//--- Makefile
VERILATOR  = verilator
TOP        = tb_emesh_mem_array
RTL_TOP    = emesh_mem_array
FILELIST   = emesh_mem_array.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q -F "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
